/* axi_xbar.f */
+incdir+verilog
verilog/axi_bus_pkg.sv
verilog/xbar_route_pkg.sv
verilog/axi_link_if.sv
verilog/write_router.sv
verilog/read_router.sv
verilog/axi_xbar_top.sv
verification/axi_xbar_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f axi_xbar.f \
	--top-module axi_xbar_tb -o axi_xbar_sim \
	&& ./obj_dir/axi_xbar_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/axi_xbar_tb.sv */
/*
 * AXI crossbar testbench
 * drives fetch and data masters from a case file, answers on the
 * system bus and timer with slave models, checks routing and data
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi_xbar_settings.svh"

// responder with random ready and valid gaps
module slave_model
	import axi_bus_pkg::*;
#(
	parameter logic [63:0] TAG = '0,
	parameter logic [1:0] RESP = 2'b00
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      awvalid,
	input  axi_id_t   awid,
	output logic      awready,
	input  logic      wvalid,
	input  logic      wlast,
	output logic      wready,
	output logic      bvalid,
	output axi_id_t   bid,
	output axi_resp_t bresp,
	input  logic      bready,
	input  logic      arvalid,
	input  axi_id_t   arid,
	input  axi_addr_t araddr,
	input  axi_len_t  arlen,
	output logic      arready,
	output logic      rvalid,
	output axi_id_t   rid,
	output axi_data_t rdata,
	output axi_resp_t rresp,
	output logic      rlast,
	input  logic      rready
);

	initial begin : write_side
		axi_id_t id;
		logic done;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		bresp = '0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			awready = ($urandom % 4) != 0;
			@(negedge clk);
			if (awvalid && awready) begin
				id = awid;
				done = 1'b0;
				while (!done) begin
					@(posedge clk);
					#1;
					awready = 1'b0;
					wready = ($urandom % 4) != 0;
					@(negedge clk);
					done = wvalid && wready && wlast;
				end
				@(posedge clk);
				#1;
				wready = 1'b0;
				bvalid = 1'b1;
				bid = id;
				bresp = RESP;
				@(negedge clk);
				while (!bready) begin
					@(negedge clk);
				end
				@(posedge clk);
				#1;
				bvalid = 1'b0;
			end
		end
	end

	initial begin : read_side
		axi_id_t id;
		axi_addr_t addr;
		int len;
		int k;
		logic moved;
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		rresp = '0;
		rlast = 1'b0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			arready = ($urandom % 4) != 0;
			@(negedge clk);
			if (arvalid && arready) begin
				id = arid;
				addr = araddr;
				len = int'(arlen);
				k = 0;
				moved = 1'b0;
				while (k <= len) begin
					@(posedge clk);
					#1;
					arready = 1'b0;
					if (moved) rvalid = 1'b0;
					if (!rvalid) rvalid = ($urandom % 4) != 0;
					rid = id;
					rdata = {32'h0, addr} ^ 64'(k) ^ TAG;
					rresp = RESP;
					rlast = (k == len);
					@(negedge clk);
					moved = rvalid && rready;
					if (moved) k++;
				end
				@(posedge clk);
				#1;
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

endmodule

module axi_xbar_tb
	import axi_bus_pkg::*;
;
	localparam logic [63:0] SYS_TAG = 64'h5151_0000_0000_0000;
	localparam logic [63:0] TIMER_TAG = 64'h7171_0000_0000_0000;
	localparam logic [1:0] SYS_RESP = 2'b00;
	localparam logic [1:0] TIMER_RESP = 2'b01;
	localparam int MAX_CASES = 32;

	logic      clk, rst_n;
	logic      fetch_arvalid, fetch_rready;
	axi_id_t   fetch_arid;
	axi_addr_t fetch_araddr;
	axi_len_t  fetch_arlen;
	logic      fetch_arready, fetch_rvalid, fetch_rlast;
	axi_id_t   fetch_rid;
	axi_data_t fetch_rdata;
	axi_resp_t fetch_rresp;
	logic      data_awvalid, data_wvalid, data_wlast, data_bready, data_arvalid, data_rready;
	axi_id_t   data_awid, data_arid;
	axi_addr_t data_awaddr, data_araddr;
	axi_len_t  data_awlen, data_arlen;
	axi_data_t data_wdata;
	axi_strb_t data_wstrb;
	logic      data_awready, data_wready, data_bvalid, data_arready, data_rvalid, data_rlast;
	axi_id_t   data_bid, data_rid;
	axi_resp_t data_bresp, data_rresp;
	axi_data_t data_rdata;
	logic      sys_awvalid, sys_wvalid, sys_wlast, sys_bready, sys_arvalid, sys_rready;
	axi_id_t   sys_awid, sys_arid;
	axi_addr_t sys_awaddr, sys_araddr;
	axi_len_t  sys_awlen, sys_arlen;
	axi_data_t sys_wdata;
	axi_strb_t sys_wstrb;
	logic      sys_awready, sys_wready, sys_bvalid, sys_arready, sys_rvalid, sys_rlast;
	axi_id_t   sys_bid, sys_rid;
	axi_resp_t sys_bresp, sys_rresp;
	axi_data_t sys_rdata;
	logic      timer_awvalid, timer_wvalid, timer_wlast, timer_bready, timer_arvalid;
	logic      timer_rready;
	axi_id_t   timer_awid, timer_arid;
	axi_addr_t timer_awaddr, timer_araddr;
	axi_len_t  timer_awlen, timer_arlen;
	axi_data_t timer_wdata;
	axi_strb_t timer_wstrb;
	logic      timer_awready, timer_wready, timer_bvalid, timer_arready, timer_rvalid;
	logic      timer_rlast;
	axi_id_t   timer_bid, timer_rid;
	axi_resp_t timer_bresp, timer_rresp;
	axi_data_t timer_rdata;

	int errors = 0;
	int n_cases = 0;
	logic fetch_active = 1'b0;
	logic data_active = 1'b0;
	logic rd_busy = 1'b0;
	logic wr_busy = 1'b0;

	// what the slave ports saw, per case
	logic      ar_tgt[$];
	axi_addr_t ar_addr[$];
	axi_id_t   ar_id[$];
	axi_len_t  ar_len[$];
	logic      aw_tgt[$];
	axi_addr_t aw_addr[$];
	axi_len_t  aw_len[$];
	logic      w_tgt[$];
	axi_data_t w_data[$];
	axi_strb_t w_strb[$];
	logic      w_last[$];

	// case table, kind 0 fetch read, 1 data read, 2 data write, 3 both read
	int        c_kind[MAX_CASES];
	axi_addr_t c_addr[MAX_CASES];
	axi_len_t  c_len[MAX_CASES];
	logic [31:0] c_seed[MAX_CASES];
	logic      c_tgt[MAX_CASES];

	axi_xbar_top uut (.*);

	slave_model #(.TAG(SYS_TAG), .RESP(SYS_RESP)) sys_model (
		.clk(clk), .rst_n(rst_n),
		.awvalid(sys_awvalid), .awid(sys_awid), .awready(sys_awready),
		.wvalid(sys_wvalid), .wlast(sys_wlast), .wready(sys_wready),
		.bvalid(sys_bvalid), .bid(sys_bid), .bresp(sys_bresp), .bready(sys_bready),
		.arvalid(sys_arvalid), .arid(sys_arid), .araddr(sys_araddr), .arlen(sys_arlen),
		.arready(sys_arready), .rvalid(sys_rvalid), .rid(sys_rid), .rdata(sys_rdata),
		.rresp(sys_rresp), .rlast(sys_rlast), .rready(sys_rready)
	);

	slave_model #(.TAG(TIMER_TAG), .RESP(TIMER_RESP)) timer_model (
		.clk(clk), .rst_n(rst_n),
		.awvalid(timer_awvalid), .awid(timer_awid), .awready(timer_awready),
		.wvalid(timer_wvalid), .wlast(timer_wlast), .wready(timer_wready),
		.bvalid(timer_bvalid), .bid(timer_bid), .bresp(timer_bresp), .bready(timer_bready),
		.arvalid(timer_arvalid), .arid(timer_arid), .araddr(timer_araddr),
		.arlen(timer_arlen), .arready(timer_arready), .rvalid(timer_rvalid),
		.rid(timer_rid), .rdata(timer_rdata), .rresp(timer_rresp), .rlast(timer_rlast),
		.rready(timer_rready)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp === act) else begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	function automatic axi_data_t beat_data(input logic [31:0] seed, input int k);
		return {seed, seed ^ 32'(k)};
	endfunction

	function automatic axi_strb_t beat_strb(input logic [31:0] seed, input int k);
		return seed[7:0] ^ 8'(k);
	endfunction

	function automatic axi_addr_t slave_addr(input axi_addr_t addr, input logic tgt);
		return tgt ? addr - `TIMER_BASE : addr;
	endfunction

	// slave port monitor, overlap and stray rvalid checks
	always @(negedge clk) begin
		if (rst_n) begin
			// a request reaches one slave only
			assert (!(sys_arvalid && timer_arvalid) && !(sys_awvalid && timer_awvalid) &&
				!(sys_wvalid && timer_wvalid)) else begin
				$display("ERROR at %0t ns: both slaves see a valid on one channel", $time);
				errors++;
			end
			if ((sys_arvalid && sys_arready) || (timer_arvalid && timer_arready)) begin
				assert (!rd_busy) else begin
					$display("ERROR at %0t ns: read accepted while another read in flight", $time);
					errors++;
				end
				rd_busy = 1'b1;
				ar_tgt.push_back(timer_arvalid);
				ar_addr.push_back(timer_arvalid ? timer_araddr : sys_araddr);
				ar_id.push_back(timer_arvalid ? timer_arid : sys_arid);
				ar_len.push_back(timer_arvalid ? timer_arlen : sys_arlen);
			end
			if ((sys_rvalid && sys_rready && sys_rlast) ||
				(timer_rvalid && timer_rready && timer_rlast)) rd_busy = 1'b0;
			assert (!(wr_busy && data_awready)) else begin
				$display("ERROR at %0t ns: write address ready while a write is in flight",
					$time);
				errors++;
			end
			if ((sys_awvalid && sys_awready) || (timer_awvalid && timer_awready)) begin
				wr_busy = 1'b1;
				aw_tgt.push_back(timer_awvalid);
				aw_addr.push_back(timer_awvalid ? timer_awaddr : sys_awaddr);
				aw_len.push_back(timer_awvalid ? timer_awlen : sys_awlen);
			end
			if ((sys_wvalid && sys_wready) || (timer_wvalid && timer_wready)) begin
				w_tgt.push_back(timer_wvalid);
				w_data.push_back(timer_wvalid ? timer_wdata : sys_wdata);
				w_strb.push_back(timer_wvalid ? timer_wstrb : sys_wstrb);
				w_last.push_back(timer_wvalid ? timer_wlast : sys_wlast);
			end
			if ((sys_bvalid && sys_bready) || (timer_bvalid && timer_bready)) wr_busy = 1'b0;
			assert (!(fetch_rvalid && !fetch_active) && !(data_rvalid && !data_active)) else begin
				$display("ERROR at %0t ns: rvalid seen at a master with no read", $time);
				errors++;
			end
		end
	end

	task automatic run_read(input logic is_data, input axi_addr_t addr, input axi_len_t len,
		input axi_id_t id, input logic tgt);
		logic fire;
		int k;
		axi_data_t exp;
		if (is_data) data_active = 1'b1;
		else fetch_active = 1'b1;
		@(posedge clk);
		#1;
		if (is_data) begin
			{data_arvalid, data_arid, data_araddr, data_arlen} = {1'b1, id, addr, len};
		end else begin
			{fetch_arvalid, fetch_arid, fetch_araddr, fetch_arlen} = {1'b1, id, addr, len};
		end
		fire = 1'b0;
		while (!fire) begin
			@(negedge clk);
			fire = is_data ? (data_arvalid && data_arready) : (fetch_arvalid && fetch_arready);
			@(posedge clk);
			#1;
		end
		if (is_data) data_arvalid = 1'b0;
		else fetch_arvalid = 1'b0;
		k = 0;
		while (k <= int'(len)) begin
			if (is_data) data_rready = ($urandom % 3) != 0;
			else fetch_rready = ($urandom % 3) != 0;
			@(negedge clk);
			exp = {32'h0, slave_addr(addr, tgt)} ^ 64'(k) ^ (tgt ? TIMER_TAG : SYS_TAG);
			if (is_data && data_rvalid && data_rready) begin
				check_value("data_rdata", exp, data_rdata);
				check_value("data_rid", 64'(id), 64'(data_rid));
				check_value("data_rresp", 64'(tgt ? TIMER_RESP : SYS_RESP), 64'(data_rresp));
				check_value("data_rlast", 64'(k == int'(len)), 64'(data_rlast));
				k++;
			end else if (!is_data && fetch_rvalid && fetch_rready) begin
				check_value("fetch_rdata", exp, fetch_rdata);
				check_value("fetch_rid", 64'(id), 64'(fetch_rid));
				check_value("fetch_rresp", 64'(SYS_RESP), 64'(fetch_rresp));
				check_value("fetch_rlast", 64'(k == int'(len)), 64'(fetch_rlast));
				k++;
			end
			@(posedge clk);
			#1;
		end
		if (is_data) {data_rready, data_active} = 2'b00;
		else {fetch_rready, fetch_active} = 2'b00;
	endtask

	task automatic run_write(input axi_addr_t addr, input axi_len_t len, input axi_id_t id,
		input logic [31:0] seed, input logic tgt);
		logic fire;
		int k;
		@(posedge clk);
		#1;
		{data_awvalid, data_awid, data_awaddr, data_awlen} = {1'b1, id, addr, len};
		fire = 1'b0;
		while (!fire) begin
			@(negedge clk);
			fire = data_awvalid && data_awready;
			@(posedge clk);
			#1;
		end
		data_awvalid = 1'b0;
		// idle address now decodes to the other slave
		data_awaddr = tgt ? `TIMER_LAST + 32'd1 : `TIMER_BASE;
		k = 0;
		while (k <= int'(len)) begin
			data_wvalid = 1'b1;
			data_wdata = beat_data(seed, k);
			data_wstrb = beat_strb(seed, k);
			data_wlast = (k == int'(len));
			@(negedge clk);
			if (data_wvalid && data_wready) k++;
			@(posedge clk);
			#1;
		end
		{data_wvalid, data_wlast} = 2'b00;
		fire = 1'b0;
		while (!fire) begin
			data_bready = ($urandom % 3) != 0;
			@(negedge clk);
			fire = data_bvalid && data_bready;
			if (fire) begin
				check_value("data_bid", 64'(id), 64'(data_bid));
				check_value("data_bresp", 64'(tgt ? TIMER_RESP : SYS_RESP), 64'(data_bresp));
			end
			@(posedge clk);
			#1;
		end
		data_bready = 1'b0;
	endtask

	task automatic load_cases();
		int fd;
		int got;
		string line;
		logic [39:0] master;
		logic [39:0] op;
		axi_addr_t addr;
		int len;
		logic [31:0] seed;
		int tgt;
		fd = $fopen("verification/xbar_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file verification/xbar_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_cases < MAX_CASES) begin
				line = "";
				void'($fgets(line, fd));
				got = $sscanf(line, "%s %s %h %d %h %d", master, op, addr, len, seed, tgt);
				if (got == 6) begin
					c_kind[n_cases] = (master == "both") ? 3 : (op == "write") ? 2 :
						(master == "data") ? 1 : 0;
					c_addr[n_cases] = addr;
					c_len[n_cases] = axi_len_t'(len);
					c_seed[n_cases] = seed;
					c_tgt[n_cases] = tgt[0];
					n_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	// the run limit scales with the number of cases
	initial begin
		wait (rst_n === 1'b1);
		repeat (n_cases * 200 + 50) @(posedge clk);
		$display("timeout: the cases did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	initial begin : main
		int i;
		int k;
		axi_id_t id;
		axi_addr_t f_addr;
		void'($urandom(32'had5d0a9e));
		clk = 1'b0;
		rst_n = 1'b0;
		{fetch_arvalid, fetch_rready, fetch_arid, fetch_araddr, fetch_arlen} = '0;
		{data_awvalid, data_awid, data_awaddr, data_awlen} = '0;
		{data_wvalid, data_wdata, data_wstrb, data_wlast, data_bready} = '0;
		{data_arvalid, data_arid, data_araddr, data_arlen, data_rready} = '0;
		load_cases();
		if (n_cases == 0) begin
			$display("no cases were loaded from the case file");
			errors++;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (i = 0; i < n_cases; i++) begin
			id = c_seed[i][3:0];
			f_addr = c_addr[i] ^ 32'h0000_8000;
			ar_tgt.delete();
			ar_addr.delete();
			ar_id.delete();
			ar_len.delete();
			aw_tgt.delete();
			aw_addr.delete();
			aw_len.delete();
			w_tgt.delete();
			w_data.delete();
			w_strb.delete();
			w_last.delete();
			case (c_kind[i])
				0: run_read(1'b0, c_addr[i], c_len[i], id, c_tgt[i]);
				1: run_read(1'b1, c_addr[i], c_len[i], id, c_tgt[i]);
				2: run_write(c_addr[i], c_len[i], id, c_seed[i], c_tgt[i]);
				default: begin
					fork
						run_read(1'b1, c_addr[i], c_len[i], id, c_tgt[i]);
						run_read(1'b0, f_addr, c_len[i], id ^ 4'h8, 1'b0);
					join
				end
			endcase
			repeat (2) @(posedge clk);
			#1;
			if (c_kind[i] == 2) begin
				check_value("aw count", 64'd1, 64'(aw_tgt.size()));
				check_value("ar count", 64'd0, 64'(ar_tgt.size()));
				check_value("w count", 64'(c_len[i]) + 64'd1, 64'(w_data.size()));
				if (aw_tgt.size() == 1) begin
					check_value("aw target", 64'(c_tgt[i]), 64'(aw_tgt[0]));
					check_value("awaddr", 64'(slave_addr(c_addr[i], c_tgt[i])), 64'(aw_addr[0]));
					check_value("awlen", 64'(c_len[i]), 64'(aw_len[0]));
				end
				for (k = 0; k < w_data.size(); k++) begin
					check_value("w target", 64'(c_tgt[i]), 64'(w_tgt[k]));
					check_value("wdata", beat_data(c_seed[i], k), w_data[k]);
					check_value("wstrb", 64'(beat_strb(c_seed[i], k)), 64'(w_strb[k]));
					check_value("wlast", 64'(k == int'(c_len[i])), 64'(w_last[k]));
				end
			end else begin
				check_value("aw count", 64'd0, 64'(aw_tgt.size()));
				check_value("ar count", (c_kind[i] == 3) ? 64'd2 : 64'd1, 64'(ar_tgt.size()));
				if (ar_tgt.size() >= 1) begin
					check_value("ar target", 64'(c_tgt[i]), 64'(ar_tgt[0]));
					check_value("araddr", 64'(slave_addr(c_addr[i], c_tgt[i])), 64'(ar_addr[0]));
					check_value("arid", 64'(id), 64'(ar_id[0]));
					check_value("arlen", 64'(c_len[i]), 64'(ar_len[0]));
				end
				// fetch follows the data burst
				if (c_kind[i] == 3 && ar_tgt.size() == 2) begin
					check_value("second ar target", 64'd0, 64'(ar_tgt[1]));
					check_value("second araddr", 64'(f_addr), 64'(ar_addr[1]));
					check_value("second arid", 64'(id ^ 4'h8), 64'(ar_id[1]));
				end
			end
		end
		$display("cases run: %0d, errors: %0d", n_cases, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/xbar_cases.txt */
# columns: master(fetch/data/both) op(read/write) addr(hex) len(beats-1) seed(hex)
# last column: expected target of the data port or fetch request, 0 system bus, 1 timer
data read 80001000 3 1a2b3c4d 0
data read 02000040 1 0badf00d 1
data write 80002000 2 c0ffee01 0
data write 02000080 0 5eed0002 1
fetch read 00001000 7 01234567 0
fetch read 02000100 1 89abcdef 0
data read 01fffff8 0 11111111 0
data read 02000000 2 22222222 1
data read 0200fff8 0 33333333 1
data read 02010000 1 44444444 0
data write 0200fff0 3 55555555 1
data write 02010008 1 66666666 0
both read 80004000 3 77777777 0
both read 02000200 2 88888888 1
data write 80003000 7 99999999 0
fetch read 00002000 3 aaaaaaaa 0
data write 02000000 1 bbbbbbbb 1
both read 01fff000 0 cccccccc 0

/* verilog/axi_bus_pkg.sv */
/*
 * AXI bus field types
 * one typedef per channel field that the crossbar carries
 */
`default_nettype none

`include "axi_xbar_settings.svh"

package axi_bus_pkg;

	typedef logic [`ADDR_W-1:0] axi_addr_t;
	typedef logic [`DATA_W-1:0] axi_data_t;
	// one enable per data byte
	typedef logic [`DATA_W/8-1:0] axi_strb_t;
	typedef logic [`ID_W-1:0] axi_id_t;
	// beats minus one
	typedef logic [`LEN_W-1:0] axi_len_t;
	typedef logic [1:0] axi_resp_t;

endpackage

`default_nettype wire

/* verilog/axi_link_if.sv */
/*
 * AXI link
 * the five AXI channels between one master and one slave
 */
`timescale 1ns/1ns
`default_nettype none

interface axi_link_if
	import axi_bus_pkg::*;
();
	logic      awvalid;
	logic      awready;
	axi_id_t   awid;
	axi_addr_t awaddr;
	axi_len_t  awlen;

	logic      wvalid;
	logic      wready;
	axi_data_t wdata;
	axi_strb_t wstrb;
	logic      wlast;

	logic      bvalid;
	logic      bready;
	axi_id_t   bid;
	axi_resp_t bresp;

	logic      arvalid;
	logic      arready;
	axi_id_t   arid;
	axi_addr_t araddr;
	axi_len_t  arlen;

	logic      rvalid;
	logic      rready;
	axi_id_t   rid;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic      rlast;

	modport master (
		output awvalid, awid, awaddr, awlen,
		input  awready,
		output wvalid, wdata, wstrb, wlast,
		input  wready,
		input  bvalid, bid, bresp,
		output bready,
		output arvalid, arid, araddr, arlen,
		input  arready,
		input  rvalid, rid, rdata, rresp, rlast,
		output rready
	);

	modport slave (
		input  awvalid, awid, awaddr, awlen,
		output awready,
		input  wvalid, wdata, wstrb, wlast,
		output wready,
		output bvalid, bid, bresp,
		input  bready,
		input  arvalid, arid, araddr, arlen,
		output arready,
		output rvalid, rid, rdata, rresp, rlast,
		input  rready
	);

endinterface

`default_nettype wire

/* verilog/axi_xbar_settings.svh */
/*
 * AXI crossbar settings
 * bus widths and the address window of the timer block
 */
`ifndef AXI_XBAR_SETTINGS_SVH
`define AXI_XBAR_SETTINGS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 64
`define ID_W 4
`define LEN_W 8

// timer window, both ends inclusive
`define TIMER_BASE 32'h0200_0000
`define TIMER_LAST 32'h0200_ffff

`endif

/* verilog/axi_xbar_top.sv */
/*
 * AXI crossbar top
 * fetch and data masters onto the system bus and the timer
 */
`timescale 1ns/1ns
`default_nettype none

module axi_xbar_top
	import axi_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// instruction fetch, read only
	input  logic      fetch_arvalid, fetch_rready,
	input  axi_id_t   fetch_arid,
	input  axi_addr_t fetch_araddr,
	input  axi_len_t  fetch_arlen,
	output logic      fetch_arready, fetch_rvalid, fetch_rlast,
	output axi_id_t   fetch_rid,
	output axi_data_t fetch_rdata,
	output axi_resp_t fetch_rresp,

	// data port
	input  logic      data_awvalid, data_wvalid, data_wlast, data_bready,
	input  logic      data_arvalid, data_rready,
	input  axi_id_t   data_awid, data_arid,
	input  axi_addr_t data_awaddr, data_araddr,
	input  axi_len_t  data_awlen, data_arlen,
	input  axi_data_t data_wdata,
	input  axi_strb_t data_wstrb,
	output logic      data_awready, data_wready, data_bvalid,
	output logic      data_arready, data_rvalid, data_rlast,
	output axi_id_t   data_bid, data_rid,
	output axi_resp_t data_bresp, data_rresp,
	output axi_data_t data_rdata,

	// system bus
	output logic      sys_awvalid, sys_wvalid, sys_wlast, sys_bready,
	output logic      sys_arvalid, sys_rready,
	output axi_id_t   sys_awid, sys_arid,
	output axi_addr_t sys_awaddr, sys_araddr,
	output axi_len_t  sys_awlen, sys_arlen,
	output axi_data_t sys_wdata,
	output axi_strb_t sys_wstrb,
	input  logic      sys_awready, sys_wready, sys_bvalid,
	input  logic      sys_arready, sys_rvalid, sys_rlast,
	input  axi_id_t   sys_bid, sys_rid,
	input  axi_resp_t sys_bresp, sys_rresp,
	input  axi_data_t sys_rdata,

	// timer, addresses relative to its base
	output logic      timer_awvalid, timer_wvalid, timer_wlast, timer_bready,
	output logic      timer_arvalid, timer_rready,
	output axi_id_t   timer_awid, timer_arid,
	output axi_addr_t timer_awaddr, timer_araddr,
	output axi_len_t  timer_awlen, timer_arlen,
	output axi_data_t timer_wdata,
	output axi_strb_t timer_wstrb,
	input  logic      timer_awready, timer_wready, timer_bvalid,
	input  logic      timer_arready, timer_rvalid, timer_rlast,
	input  axi_id_t   timer_bid, timer_rid,
	input  axi_resp_t timer_bresp, timer_rresp,
	input  axi_data_t timer_rdata
);

	axi_link_if fetch_link ();
	axi_link_if data_link ();
	axi_link_if sys_link ();
	axi_link_if timer_link ();

	// fetch write channels stay unconnected
	assign {fetch_link.arvalid, fetch_link.arid, fetch_link.araddr, fetch_link.arlen} =
		{fetch_arvalid, fetch_arid, fetch_araddr, fetch_arlen};
	assign fetch_arready = fetch_link.arready;
	assign {fetch_rvalid, fetch_rid, fetch_rdata, fetch_rresp, fetch_rlast} =
		{fetch_link.rvalid, fetch_link.rid, fetch_link.rdata, fetch_link.rresp, fetch_link.rlast};
	assign fetch_link.rready = fetch_rready;

	assign {data_link.awvalid, data_link.awid, data_link.awaddr, data_link.awlen} =
		{data_awvalid, data_awid, data_awaddr, data_awlen};
	assign data_awready = data_link.awready;
	assign {data_link.wvalid, data_link.wdata, data_link.wstrb, data_link.wlast} =
		{data_wvalid, data_wdata, data_wstrb, data_wlast};
	assign data_wready = data_link.wready;
	assign {data_bvalid, data_bid, data_bresp} = {data_link.bvalid, data_link.bid, data_link.bresp};
	assign data_link.bready = data_bready;
	assign {data_link.arvalid, data_link.arid, data_link.araddr, data_link.arlen} =
		{data_arvalid, data_arid, data_araddr, data_arlen};
	assign data_arready = data_link.arready;
	assign {data_rvalid, data_rid, data_rdata, data_rresp, data_rlast} =
		{data_link.rvalid, data_link.rid, data_link.rdata, data_link.rresp, data_link.rlast};
	assign data_link.rready = data_rready;

	assign {sys_awvalid, sys_awid, sys_awaddr, sys_awlen} =
		{sys_link.awvalid, sys_link.awid, sys_link.awaddr, sys_link.awlen};
	assign sys_link.awready = sys_awready;
	assign {sys_wvalid, sys_wdata, sys_wstrb, sys_wlast} =
		{sys_link.wvalid, sys_link.wdata, sys_link.wstrb, sys_link.wlast};
	assign sys_link.wready = sys_wready;
	assign {sys_link.bvalid, sys_link.bid, sys_link.bresp} = {sys_bvalid, sys_bid, sys_bresp};
	assign sys_bready = sys_link.bready;
	assign {sys_arvalid, sys_arid, sys_araddr, sys_arlen} =
		{sys_link.arvalid, sys_link.arid, sys_link.araddr, sys_link.arlen};
	assign sys_link.arready = sys_arready;
	assign {sys_link.rvalid, sys_link.rid, sys_link.rdata, sys_link.rresp, sys_link.rlast} =
		{sys_rvalid, sys_rid, sys_rdata, sys_rresp, sys_rlast};
	assign sys_rready = sys_link.rready;

	assign {timer_awvalid, timer_awid, timer_awaddr, timer_awlen} =
		{timer_link.awvalid, timer_link.awid, timer_link.awaddr, timer_link.awlen};
	assign timer_link.awready = timer_awready;
	assign {timer_wvalid, timer_wdata, timer_wstrb, timer_wlast} =
		{timer_link.wvalid, timer_link.wdata, timer_link.wstrb, timer_link.wlast};
	assign timer_link.wready = timer_wready;
	assign {timer_link.bvalid, timer_link.bid, timer_link.bresp} =
		{timer_bvalid, timer_bid, timer_bresp};
	assign timer_bready = timer_link.bready;
	assign {timer_arvalid, timer_arid, timer_araddr, timer_arlen} =
		{timer_link.arvalid, timer_link.arid, timer_link.araddr, timer_link.arlen};
	assign timer_link.arready = timer_arready;
	assign {timer_link.rvalid, timer_link.rid, timer_link.rdata, timer_link.rresp,
		timer_link.rlast} = {timer_rvalid, timer_rid, timer_rdata, timer_rresp, timer_rlast};
	assign timer_rready = timer_link.rready;

	write_router u_write_router (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_link  (data_link),
		.sys_link   (sys_link),
		.timer_link (timer_link)
	);

	read_router u_read_router (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_link (fetch_link),
		.data_link  (data_link),
		.sys_link   (sys_link),
		.timer_link (timer_link)
	);

endmodule

`default_nettype wire

/* verilog/read_router.sv */
/*
 * read router
 * arbitrates fetch and data reads, data port first, and returns
 * the burst to its owner; one read in flight until the last beat
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi_xbar_settings.svh"

module read_router
	import axi_bus_pkg::*;
	import xbar_route_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	axi_link_if.slave  fetch_link,
	axi_link_if.slave  data_link,
	axi_link_if.master sys_link,
	axi_link_if.master timer_link
);

	path_state_e  state;
	read_owner_e  owner;
	xbar_target_e target;
	logic         pend;
	read_owner_e  pend_owner;
	read_owner_e  grant;
	xbar_target_e ar_target;
	logic         req_valid;
	axi_id_t      req_id;
	axi_addr_t    req_addr;
	axi_len_t     req_len;
	logic         req_ready;
	logic         rsp_valid;
	axi_id_t      rsp_id;
	axi_data_t    rsp_data;
	axi_resp_t    rsp_resp;
	logic         rsp_last;
	logic         rsp_ready;
	logic         ar_fire;
	logic         r_fire;

	// a request already shown to a slave keeps its grant
	assign grant = pend ? pend_owner : (data_link.arvalid ? DATA : FETCH);
	assign req_valid = (grant == DATA) ? data_link.arvalid : fetch_link.arvalid;
	assign req_id = (grant == DATA) ? data_link.arid : fetch_link.arid;
	assign req_addr = (grant == DATA) ? data_link.araddr : fetch_link.araddr;
	assign req_len = (grant == DATA) ? data_link.arlen : fetch_link.arlen;

	// fetch always goes to the system bus
	assign ar_target = ((grant == DATA) && in_timer_window(data_link.araddr)) ? TIMER : SYS_BUS;
	assign req_ready = (ar_target == TIMER) ? timer_link.arready : sys_link.arready;
	assign ar_fire = (state == IDLE) && req_valid && req_ready;

	assign rsp_valid = (target == TIMER) ? timer_link.rvalid : sys_link.rvalid;
	assign rsp_id = (target == TIMER) ? timer_link.rid : sys_link.rid;
	assign rsp_data = (target == TIMER) ? timer_link.rdata : sys_link.rdata;
	assign rsp_resp = (target == TIMER) ? timer_link.rresp : sys_link.rresp;
	assign rsp_last = (target == TIMER) ? timer_link.rlast : sys_link.rlast;
	assign rsp_ready = (owner == DATA) ? data_link.rready : fetch_link.rready;
	assign r_fire = (state == BUSY) && rsp_valid && rsp_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			owner <= FETCH;
			target <= SYS_BUS;
		end else if (state == IDLE) begin
			if (ar_fire) begin
				state <= BUSY;
				owner <= grant;
				target <= ar_target;
			end
		end else if (r_fire && rsp_last) begin
			state <= IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 1'b0;
			pend_owner <= FETCH;
		end else begin
			pend <= (state == IDLE) && req_valid && !req_ready;
			pend_owner <= grant;
		end
	end

	// ar to the decoded slave, ready back to the granted master
	always_comb begin
		sys_link.arvalid = 1'b0;
		sys_link.arid = '0;
		sys_link.araddr = '0;
		sys_link.arlen = '0;
		timer_link.arvalid = 1'b0;
		timer_link.arid = '0;
		timer_link.araddr = '0;
		timer_link.arlen = '0;
		fetch_link.arready = 1'b0;
		data_link.arready = 1'b0;
		if (state == IDLE) begin
			if (ar_target == TIMER) begin
				timer_link.arvalid = req_valid;
				timer_link.arid = req_id;
				timer_link.araddr = req_addr - `TIMER_BASE;
				timer_link.arlen = req_len;
			end else begin
				sys_link.arvalid = req_valid;
				sys_link.arid = req_id;
				sys_link.araddr = req_addr;
				sys_link.arlen = req_len;
			end
			if (grant == DATA) begin
				data_link.arready = req_ready;
			end else begin
				fetch_link.arready = req_ready;
			end
		end
	end

	// r to the owner only
	always_comb begin
		fetch_link.rvalid = 1'b0;
		fetch_link.rid = '0;
		fetch_link.rdata = '0;
		fetch_link.rresp = '0;
		fetch_link.rlast = 1'b0;
		data_link.rvalid = 1'b0;
		data_link.rid = '0;
		data_link.rdata = '0;
		data_link.rresp = '0;
		data_link.rlast = 1'b0;
		sys_link.rready = 1'b0;
		timer_link.rready = 1'b0;
		if (state == BUSY) begin
			if (owner == DATA) begin
				data_link.rvalid = rsp_valid;
				data_link.rid = rsp_id;
				data_link.rdata = rsp_data;
				data_link.rresp = rsp_resp;
				data_link.rlast = rsp_last;
			end else begin
				fetch_link.rvalid = rsp_valid;
				fetch_link.rid = rsp_id;
				fetch_link.rdata = rsp_data;
				fetch_link.rresp = rsp_resp;
				fetch_link.rlast = rsp_last;
			end
			if (target == TIMER) begin
				timer_link.rready = rsp_ready;
			end else begin
				sys_link.rready = rsp_ready;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/write_router.sv */
/*
 * write router
 * steers data port writes to the system bus or the timer,
 * one write in flight from aw handshake to b handshake
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi_xbar_settings.svh"

module write_router
	import xbar_route_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	axi_link_if.slave  data_link,
	axi_link_if.master sys_link,
	axi_link_if.master timer_link
);

	path_state_e  state;
	xbar_target_e target;
	xbar_target_e aw_target;
	logic         aw_fire;
	logic         b_fire;

	assign aw_target = in_timer_window(data_link.awaddr) ? TIMER : SYS_BUS;
	assign aw_fire = data_link.awvalid && data_link.awready;
	assign b_fire = data_link.bvalid && data_link.bready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			target <= SYS_BUS;
		end else if (state == IDLE) begin
			if (aw_fire) begin
				state <= BUSY;
				target <= aw_target;
			end
		end else if (b_fire) begin
			state <= IDLE;
		end
	end

	// aw passes through only while idle
	always_comb begin
		sys_link.awvalid = 1'b0;
		sys_link.awid = '0;
		sys_link.awaddr = '0;
		sys_link.awlen = '0;
		timer_link.awvalid = 1'b0;
		timer_link.awid = '0;
		timer_link.awaddr = '0;
		timer_link.awlen = '0;
		data_link.awready = 1'b0;
		if (state == IDLE) begin
			if (aw_target == TIMER) begin
				timer_link.awvalid = data_link.awvalid;
				timer_link.awid = data_link.awid;
				timer_link.awaddr = data_link.awaddr - `TIMER_BASE;
				timer_link.awlen = data_link.awlen;
				data_link.awready = timer_link.awready;
			end else begin
				sys_link.awvalid = data_link.awvalid;
				sys_link.awid = data_link.awid;
				sys_link.awaddr = data_link.awaddr;
				sys_link.awlen = data_link.awlen;
				data_link.awready = sys_link.awready;
			end
		end
	end

	// w and b follow the stored target
	always_comb begin
		sys_link.wvalid = 1'b0;
		sys_link.wdata = '0;
		sys_link.wstrb = '0;
		sys_link.wlast = 1'b0;
		sys_link.bready = 1'b0;
		timer_link.wvalid = 1'b0;
		timer_link.wdata = '0;
		timer_link.wstrb = '0;
		timer_link.wlast = 1'b0;
		timer_link.bready = 1'b0;
		data_link.wready = 1'b0;
		data_link.bvalid = 1'b0;
		data_link.bid = '0;
		data_link.bresp = '0;
		if (state == BUSY) begin
			if (target == TIMER) begin
				timer_link.wvalid = data_link.wvalid;
				timer_link.wdata = data_link.wdata;
				timer_link.wstrb = data_link.wstrb;
				timer_link.wlast = data_link.wlast;
				data_link.wready = timer_link.wready;
				data_link.bvalid = timer_link.bvalid;
				data_link.bid = timer_link.bid;
				data_link.bresp = timer_link.bresp;
				timer_link.bready = data_link.bready;
			end else begin
				sys_link.wvalid = data_link.wvalid;
				sys_link.wdata = data_link.wdata;
				sys_link.wstrb = data_link.wstrb;
				sys_link.wlast = data_link.wlast;
				data_link.wready = sys_link.wready;
				data_link.bvalid = sys_link.bvalid;
				data_link.bid = sys_link.bid;
				data_link.bresp = sys_link.bresp;
				sys_link.bready = data_link.bready;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/xbar_route_pkg.sv */
/*
 * crossbar routing types
 * slave targets, read owner, path states and the timer decode
 */
`default_nettype none

`include "axi_xbar_settings.svh"

package xbar_route_pkg;

	import axi_bus_pkg::*;

	typedef enum logic {SYS_BUS = 1'b0, TIMER = 1'b1} xbar_target_e;
	typedef enum logic {FETCH = 1'b0, DATA = 1'b1} read_owner_e;
	typedef enum logic {IDLE = 1'b0, BUSY = 1'b1} path_state_e;

	// true inside the inclusive timer window
	function automatic logic in_timer_window(input axi_addr_t addr);
		return (addr >= `TIMER_BASE) && (addr <= `TIMER_LAST);
	endfunction

endpackage

`default_nettype wire
